//--- Makefile
# Verilator build and run of the trellis monitor testbench

TOP       ?= trellisMonitor_tb
FILELIST  ?= trellisMonitor.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/dacMux.sv
// needs at least 3 clocks between symEn strobes for a clean double-rate enable
`timescale 1ns/100ps
`include "trellisMon_params.svh"

module dacMux (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  trellisMonPkg::dacSelT     dac0Select,
   input  trellisMonPkg::dacSelT     dac1Select,
   input  trellisMonPkg::dacSelT     dac2Select,
   input  trellisMonPkg::iqSampleT   iqLatched,
   input  trellisMonPkg::symbolInfoT symInfo,
   input  trellisMonPkg::phSatT      phSat,
   output trellisMonPkg::dacOutT     dac0,
   output trellisMonPkg::dacOutT     dac1,
   output trellisMonPkg::dacOutT     dac2,
   output logic                      quadrarySym2xEnOut
);

   logic [`DAC_BITS-1:0] phErrWord;
   logic [`DAC_BITS-1:0] indexWord;
   logic [`DAC_BITS-1:0] phSatWord;
   logic [`DAC_BITS-1:0] dac0Data;
   logic [`DAC_BITS-1:0] dac1Data;
   logic [`DAC_BITS-1:0] dac2Data;
   logic                 symEnDly;

   // --------------------
   // source formatting
   // --------------------
   // all sources left justified in the DAC word
   assign phErrWord = {symInfo.phaseErr, 8'b0};
   // leading zero of the 19-bit index word falls off the top
   assign indexWord = {symInfo.index, 12'b0};
   assign phSatWord = {phSat, 10'b0};

   // one select code to one DAC word
   // unknown codes show the raw phase error
   function automatic logic [`DAC_BITS-1:0] selectSource(input trellisMonPkg::dacSelT sel);
      case (sel)
         `DAC_TRELLIS_I:     return iqLatched.i;
         `DAC_TRELLIS_Q:     return iqLatched.q;
         `DAC_TRELLIS_PHERR: return phErrWord;
         `DAC_TRELLIS_INDEX: return indexWord;
         `DAC_TRELLIS_PHSAT: return phSatWord;
         default:            return phErrWord;
      endcase
   endfunction

   // --------------------
   // channel registers
   // --------------------
   always_ff @(posedge clk) begin
      dac0Data <= selectSource(dac0Select);
      dac1Data <= selectSource(dac1Select);
      dac2Data <= selectSource(dac2Select);
   end

   // symbol strobe one clock late
   // shared by the syncs and the 2x enable
   always_ff @(posedge clk) begin
      if (reset) begin
         symEnDly <= 1'b0;
      end
      else begin
         symEnDly <= symEn;
      end
   end

   assign dac0 = '{sync: symEnDly, data: dac0Data};
   assign dac1 = '{sync: symEnDly, data: dac1Data};
   assign dac2 = '{sync: symEnDly, data: dac2Data};

   // two-cycle pulse per symbol for the line decoder
   assign quadrarySym2xEnOut = symEn | symEnDly;

endmodule

//--- src/phaseErrSat.sv
// phaseErr must be stable across symEn; phSat trails it by two symbol strobes
`timescale 1ns/100ps
`include "trellisMon_params.svh"

module phaseErrSat (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   symEn,
   input  trellisMonPkg::phaseErrT phaseErr,
   output trellisMonPkg::phSatT    phSat
);

   logic                 sign;
   logic [3:0]           topBits;
   trellisMonPkg::phSatT dataBits;
   logic                 satPos;
   logic                 satNeg;

   // sign and the four bits that must all match it
   assign sign = phaseErr[`PHERR_BITS-1];
   assign topBits = phaseErr[`PHERR_BITS-1 -: 4];

   // --------------------
   // stage one
   // --------------------
   // doubled value and overflow flags
   // positive overflow when any top bit is set
   // negative overflow unless all top bits are set
   always_ff @(posedge clk) begin
      if (symEn) begin
         dataBits <= {phaseErr[`PHSAT_BITS-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         satPos <= 1'b0;
         satNeg <= 1'b0;
      end
      else if (symEn) begin
         satPos <= !sign && (topBits != 4'b0000);
         satNeg <= sign && (topBits != 4'b1111);
      end
   end

   // --------------------
   // stage two
   // --------------------
   // clamp to plus or minus full scale
   // 8'h81 keeps the negative range symmetric
   always_ff @(posedge clk) begin
      if (reset) begin
         phSat <= '0;
      end
      else if (symEn) begin
         if (satPos) begin
            phSat <= 8'sh7f;
         end
         else if (satNeg) begin
            phSat <= 8'sh81;
         end
         else begin
            phSat <= dataBits;
         end
      end
   end

endmodule

//--- src/symbolCapture.sv
// iqIn must be valid with sym2xEn and symInfoIn with symEn; outputs lag the strobe by one clock
`timescale 1ns/100ps

module symbolCapture (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     symEn,
   input  logic                     sym2xEn,
   input  trellisMonPkg::iqSampleT  iqIn,
   input  trellisMonPkg::symbolInfoT symInfoIn,
   output trellisMonPkg::iqSampleT  iqLatched,
   output trellisMonPkg::symbolInfoT symInfo
);

   // --------------------
   // half-symbol sample latch
   // --------------------
   // i and q held between half-symbol strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         iqLatched <= '0;
      end
      else if (sym2xEn) begin
         iqLatched <= iqIn;
      end
   end

   // --------------------
   // symbol-rate decoder capture
   // --------------------
   // phase error and path index from the trellis decoder
   // later stages work only from this stable copy
   always_ff @(posedge clk) begin
      if (reset) begin
         symInfo <= '0;
      end
      else if (symEn) begin
         symInfo <= symInfoIn;
      end
   end

endmodule

//--- src/trellisMonPkg.sv
// shared types only; widths come from the params header and must be edited there
`include "trellisMon_params.svh"

package trellisMonPkg;

   // --------------------
   // baseband samples
   // --------------------
   typedef logic signed [`SAMPLE_BITS-1:0] sampleT;

   // one complex sample pair
   typedef struct packed {
      sampleT i;
      sampleT q;
   } iqSampleT;

   // --------------------
   // decoder results
   // --------------------
   typedef logic signed [`PHERR_BITS-1:0] phaseErrT;
   typedef logic signed [`PHSAT_BITS-1:0] phSatT;
   typedef logic [`INDEX_BITS-1:0] indexT;

   // per-symbol output of the trellis decoder
   typedef struct packed {
      phaseErrT phaseErr;
      indexT index;
   } symbolInfoT;

   // --------------------
   // register bus
   // --------------------
   // single-cycle write strobe with its address and data
   typedef struct packed {
      logic wr;
      logic [`ADDR_BITS-1:0] addr;
      logic [`DATA_BITS-1:0] data;
   } busWriteT;

   typedef logic [`DECAY_BITS-1:0] decayT;

   // --------------------
   // DAC channels
   // --------------------
   typedef logic [`DAC_SEL_BITS-1:0] dacSelT;

   // sync marks the symbol the data belongs to
   typedef struct packed {
      logic sync;
      logic [`DAC_BITS-1:0] data;
   } dacOutT;

endpackage

//--- src/trellisMon_params.svh
// widths and codes are fixed here; DAC select codes above 4 fall back to the phase error source
`ifndef TRELLISMON_PARAMS_SVH
`define TRELLISMON_PARAMS_SVH

// --------------------
// datapath widths
// --------------------
`define SAMPLE_BITS 18
`define PHERR_BITS 10
`define PHSAT_BITS 8
`define INDEX_BITS 6

// --------------------
// register bus
// --------------------
`define ADDR_BITS 12
`define DATA_BITS 32

// --------------------
// test DAC channels
// --------------------
`define DAC_SEL_BITS 4
`define DAC_BITS 18

// monitor source codes
`define DAC_TRELLIS_I 4'd0
`define DAC_TRELLIS_Q 4'd1
`define DAC_TRELLIS_PHERR 4'd2
`define DAC_TRELLIS_INDEX 4'd3
`define DAC_TRELLIS_PHSAT 4'd4

// path metric decay register
`define DECAY_BITS 8
`define TRELLIS_DECAY_ADDR 12'h200
// full decay until software writes something else
`define DECAY_RESET 8'hff

`endif

//--- src/trellisMonitor.sv
// decoder results arrive as inputs; strobes are single cycle with no back-pressure
`timescale 1ns/100ps
`include "trellisMon_params.svh"

module trellisMonitor (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  logic                      sym2xEn,
   input  trellisMonPkg::iqSampleT   iqIn,
   input  trellisMonPkg::symbolInfoT symInfoIn,
   input  trellisMonPkg::busWriteT   busWr,
   input  logic [`ADDR_BITS-1:0]     busAddr,
   output logic [`DATA_BITS-1:0]     busDout,
   input  trellisMonPkg::dacSelT     dac0Select,
   input  trellisMonPkg::dacSelT     dac1Select,
   input  trellisMonPkg::dacSelT     dac2Select,
   output trellisMonPkg::dacOutT     dac0,
   output trellisMonPkg::dacOutT     dac1,
   output trellisMonPkg::dacOutT     dac2,
   output trellisMonPkg::phSatT      phSat,
   output trellisMonPkg::decayT      decayFactor,
   output logic                      quadrarySym2xEnOut
);

   // stable copies from the capture stage
   trellisMonPkg::iqSampleT   iqLatched;
   trellisMonPkg::symbolInfoT symInfo;

   // --------------------
   // input side
   // --------------------
   symbolCapture symbolCapture_inst (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .sym2xEn   (sym2xEn),
      .iqIn      (iqIn),
      .symInfoIn (symInfoIn),
      .iqLatched (iqLatched),
      .symInfo   (symInfo)
   );

   trellisRegs trellisRegs_inst (
      .clk         (clk),
      .reset       (reset),
      .busWr       (busWr),
      .busAddr     (busAddr),
      .busDout     (busDout),
      .decayFactor (decayFactor)
   );

   // --------------------
   // processing
   // --------------------
   phaseErrSat phaseErrSat_inst (
      .clk      (clk),
      .reset    (reset),
      .symEn    (symEn),
      .phaseErr (symInfo.phaseErr),
      .phSat    (phSat)
   );

   // --------------------
   // output side
   // --------------------
   dacMux dacMux_inst (
      .clk                (clk),
      .reset              (reset),
      .symEn              (symEn),
      .dac0Select         (dac0Select),
      .dac1Select         (dac1Select),
      .dac2Select         (dac2Select),
      .iqLatched          (iqLatched),
      .symInfo            (symInfo),
      .phSat              (phSat),
      .dac0               (dac0),
      .dac1               (dac1),
      .dac2               (dac2),
      .quadrarySym2xEnOut (quadrarySym2xEnOut)
   );

endmodule

//--- src/trellisRegs.sv
// only the decay register is mapped; writes are synchronous and unmapped reads return zero
`timescale 1ns/100ps
`include "trellisMon_params.svh"

module trellisRegs (
   input  logic                   clk,
   input  logic                   reset,
   input  trellisMonPkg::busWriteT busWr,
   input  logic [`ADDR_BITS-1:0]  busAddr,
   output logic [`DATA_BITS-1:0]  busDout,
   output trellisMonPkg::decayT   decayFactor
);

   logic decayWrHit;
   logic decayRdHit;

   // --------------------
   // address decode
   // --------------------
   // write side uses the address carried with the strobe
   assign decayWrHit = busWr.wr && (busWr.addr == `TRELLIS_DECAY_ADDR);

   // read side uses the separate read address
   assign decayRdHit = (busAddr == `TRELLIS_DECAY_ADDR);

   // --------------------
   // decay factor register
   // --------------------
   // low byte of the bus data only
   // upper bits are ignored on write
   always_ff @(posedge clk) begin
      if (reset) begin
         decayFactor <= `DECAY_RESET;
      end
      else if (decayWrHit) begin
         decayFactor <= busWr.data[`DECAY_BITS-1:0];
      end
   end

   // --------------------
   // readback
   // --------------------
   // combinational, follows busAddr in the same cycle
   // zero extended to the bus width
   always_comb begin
      if (decayRdHit) begin
         busDout = {{(`DATA_BITS-`DECAY_BITS){1'b0}}, decayFactor};
      end
      else begin
         busDout = '0;
      end
   end

endmodule

//--- trellisMonitor.f
+incdir+src
+incdir+verif
src/trellisMonPkg.sv
src/symbolCapture.sv
src/trellisRegs.sv
src/phaseErrSat.sv
src/dacMux.sv
src/trellisMonitor.sv
verif/trellisMonitor_tb.sv

//--- verif/trellisMonitorTests.svh
// directed tests, included inside the testbench module; they rely on its checkers and runSymbol
`ifndef TRELLISMONITORTESTS_SVH
`define TRELLISMONITORTESTS_SVH

// --------------------
// bus and select helpers
// --------------------
task automatic writeBus(input logic [`ADDR_BITS-1:0] addr, input logic [`DATA_BITS-1:0] data);
   @(posedge clk);
   #10;
   busWr = '{wr: 1'b1, addr: addr, data: data};
   @(posedge clk);
   #10;
   busWr.wr = 1'b0;
endtask

// readback settles within the cycle
task automatic readAddr(input logic [`ADDR_BITS-1:0] addr);
   @(posedge clk);
   #10;
   busAddr = addr;
   #50;
endtask

task automatic setSelects(input trellisMonPkg::dacSelT sel0, input trellisMonPkg::dacSelT sel1,
                          input trellisMonPkg::dacSelT sel2);
   @(posedge clk);
   #10;
   dac0Select = sel0;
   dac1Select = sel1;
   dac2Select = sel2;
endtask

task automatic runRandomSymbol();
   runSymbol(randomIq(), randomIq(), randomInfo());
endtask

task automatic phaseSymbol(input trellisMonPkg::phaseErrT p);
   trellisMonPkg::symbolInfoT info;
   info = randomInfo();
   info.phaseErr = p;
   runSymbol(randomIq(), randomIq(), info);
endtask

// --------------------
// tests
// --------------------
task automatic checkResetState();
   #50;
   compareBit(dac0.sync, 1'b0, "dac0 sync after reset");
   compareBit(dac1.sync, 1'b0, "dac1 sync after reset");
   compareBit(dac2.sync, 1'b0, "dac2 sync after reset");
   compareBit(quadrarySym2xEnOut, 1'b0, "2x enable after reset");
   comparePhSat(phSat, 8'h00, "phSat after reset");
   compareDecay(decayFactor, `DECAY_RESET, "decay after reset");
   compareDecay(busDout[`DECAY_BITS-1:0], `DECAY_RESET, "decay readback after reset");
   compareBit(|busDout[`DATA_BITS-1:`DECAY_BITS], 1'b0, "readback upper bits after reset");
endtask

task automatic exerciseDecayReg();
   logic [31:0]          r;
   trellisMonPkg::decayT held;
   repeat (8) begin
      r = $random(seed);
      writeBus(`TRELLIS_DECAY_ADDR, r);
      readAddr(`TRELLIS_DECAY_ADDR);
      compareDecay(decayFactor, r[`DECAY_BITS-1:0], "decay after write");
      compareDecay(busDout[`DECAY_BITS-1:0], r[`DECAY_BITS-1:0], "decay readback");
      compareBit(|busDout[`DATA_BITS-1:`DECAY_BITS], 1'b0, "readback upper bits");
   end
   // a write to the next word leaves decay alone
   held = decayFactor;
   writeBus(`TRELLIS_DECAY_ADDR + 12'h004, ~{24'b0, held});
   readAddr(`TRELLIS_DECAY_ADDR);
   compareDecay(decayFactor, held, "decay after write elsewhere");
   repeat (6) begin
      r = $random(seed);
      if (r[`ADDR_BITS-1:0] == `TRELLIS_DECAY_ADDR) begin
         r[0] = 1'b1;
      end
      readAddr(r[`ADDR_BITS-1:0]);
      compareDecay(busDout[`DECAY_BITS-1:0], 8'h00, "unmapped readback");
      compareBit(|busDout[`DATA_BITS-1:`DECAY_BITS], 1'b0, "unmapped readback upper bits");
   end
endtask

task automatic checkDacSources();
   setSelects(`DAC_TRELLIS_I, `DAC_TRELLIS_Q, `DAC_TRELLIS_INDEX);
   repeat (16) runRandomSymbol();
   // 4'd9 is not a source code
   setSelects(`DAC_TRELLIS_PHERR, `DAC_TRELLIS_PHSAT, 4'd9);
   repeat (16) runRandomSymbol();
endtask

task automatic sweepPhaseErr();
   logic [31:0] r;
   // in range, then overflow, then the edges of the range
   phaseSymbol(10'sd25);
   phaseSymbol(-10'sd30);
   phaseSymbol(10'sd200);
   phaseSymbol(-10'sd300);
   phaseSymbol(10'sd63);
   phaseSymbol(10'sd64);
   phaseSymbol(-10'sd64);
   phaseSymbol(-10'sd65);
   repeat (40) begin
      r = $random(seed);
      phaseSymbol(r[`PHERR_BITS-1:0]);
   end
   // sign extended from bit 6 so all stay in range
   repeat (16) begin
      r = $random(seed);
      phaseSymbol({{3{r[6]}}, r[6:0]});
   end
   // two more strobes push the last values out
   repeat (2) runRandomSymbol();
endtask

task automatic checkSym2xEnable();
   repeat (4) begin
      @(posedge clk);
      #60;
      compareBit(quadrarySym2xEnOut, 1'b0, "2x enable with no strobe");
      requireSyncsLow("with no strobe");
   end
   repeat (16) runRandomSymbol();
endtask

`endif

//--- verif/trellisMonitor_tb.sv
// symEn is driven every 4 clocks by runSymbol; expected values come from a history of driven inputs
`timescale 1ns/100ps
`include "trellisMon_params.svh"

module trellisMonitor_tb;

   // the full sequence runs about 500 clocks
   localparam int maxCycles = 2000;

   logic                      clk;
   logic                      reset;
   logic                      symEn;
   logic                      sym2xEn;
   trellisMonPkg::iqSampleT   iqIn;
   trellisMonPkg::symbolInfoT symInfoIn;
   trellisMonPkg::busWriteT   busWr;
   logic [`ADDR_BITS-1:0]     busAddr;
   logic [`DATA_BITS-1:0]     busDout;
   trellisMonPkg::dacSelT     dac0Select;
   trellisMonPkg::dacSelT     dac1Select;
   trellisMonPkg::dacSelT     dac2Select;
   trellisMonPkg::dacOutT     dac0;
   trellisMonPkg::dacOutT     dac1;
   trellisMonPkg::dacOutT     dac2;
   trellisMonPkg::phSatT      phSat;
   trellisMonPkg::decayT      decayFactor;
   logic                      quadrarySym2xEnOut;

   integer seed;
   int     cycleCount;
   int     dacErrors;
   int     phSatErrors;
   int     decayErrors;
   int     bitErrors;

   // last half-symbol sample and every symbol result driven so far
   trellisMonPkg::iqSampleT   lastIq;
   trellisMonPkg::symbolInfoT infoHist[$];

   trellisMonitor trellisMonitor_inst (
      .clk                (clk),
      .reset              (reset),
      .symEn              (symEn),
      .sym2xEn            (sym2xEn),
      .iqIn               (iqIn),
      .symInfoIn          (symInfoIn),
      .busWr              (busWr),
      .busAddr            (busAddr),
      .busDout            (busDout),
      .dac0Select         (dac0Select),
      .dac1Select         (dac1Select),
      .dac2Select         (dac2Select),
      .dac0               (dac0),
      .dac1               (dac1),
      .dac2               (dac2),
      .phSat              (phSat),
      .decayFactor        (decayFactor),
      .quadrarySym2xEnOut (quadrarySym2xEnOut)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   // --------------------
   // timeout
   // --------------------
   initial begin
      cycleCount = 0;
      while (cycleCount < maxCycles) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("timeout: the tests did not finish within %0d clock cycles", maxCycles);
      $display("Verification failed");
      $finish;
   end

   // --------------------
   // checkers
   // --------------------
   task automatic compareDac(input trellisMonPkg::dacOutT actual,
                             input trellisMonPkg::dacOutT expected, input string what);
      if (actual !== expected) begin
         dacErrors++;
         $display("FAILED at %0t: %s got sync %b data %h, expected sync %b data %h",
                  $time, what, actual.sync, actual.data, expected.sync, expected.data);
      end
   endtask

   task automatic comparePhSat(input trellisMonPkg::phSatT actual,
                               input trellisMonPkg::phSatT expected, input string what);
      if (actual !== expected) begin
         phSatErrors++;
         $display("FAILED at %0t: %s got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic compareDecay(input trellisMonPkg::decayT actual,
                               input trellisMonPkg::decayT expected, input string what);
      if (actual !== expected) begin
         decayErrors++;
         $display("FAILED at %0t: %s got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic compareBit(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         bitErrors++;
         $display("FAILED at %0t: %s got %b, expected %b", $time, what, actual, expected);
      end
   endtask

   // no channel flags a symbol outside its sync cycle
   task automatic requireSyncsLow(input string when);
      compareBit(dac0.sync, 1'b0, {"dac0 sync ", when});
      compareBit(dac1.sync, 1'b0, {"dac1 sync ", when});
      compareBit(dac2.sync, 1'b0, {"dac2 sync ", when});
   endtask

   // --------------------
   // reference rules
   // --------------------
   // doubled value while the top four bits agree, else clamp by sign
   function automatic trellisMonPkg::phSatT expectedSat(input trellisMonPkg::phaseErrT p);
      logic [3:0] top;
      top = p[`PHERR_BITS-1 -: 4];
      if (top == 4'b0000) begin
         return {p[6:0], 1'b0};
      end
      else if (p > 0) begin
         return 8'h7f;
      end
      else if (top == 4'b1111) begin
         return {p[6:0], 1'b0};
      end
      return 8'h81;
   endfunction

   // DAC word of one source as seen in a sync cycle
   function automatic trellisMonPkg::dacOutT syncedWord(input trellisMonPkg::dacSelT sel,
         input trellisMonPkg::iqSampleT iq, input trellisMonPkg::symbolInfoT info,
         input trellisMonPkg::phSatT ps);
      trellisMonPkg::dacOutT word;
      word.sync = 1'b1;
      case (sel)
         `DAC_TRELLIS_I:     word.data = iq.i;
         `DAC_TRELLIS_Q:     word.data = iq.q;
         // leading zero of the index format sits above bit 17
         `DAC_TRELLIS_INDEX: word.data = {info.index, 12'b0};
         `DAC_TRELLIS_PHSAT: word.data = {ps, 10'b0};
         // phase error for its own code and every unused one
         default:            word.data = {info.phaseErr, 8'b0};
      endcase
      return word;
   endfunction

   function automatic trellisMonPkg::iqSampleT randomIq();
      logic [31:0]             r;
      trellisMonPkg::iqSampleT iq;
      r = $random(seed);
      iq.i = r[`SAMPLE_BITS-1:0];
      r = $random(seed);
      iq.q = r[`SAMPLE_BITS-1:0];
      return iq;
   endfunction

   function automatic trellisMonPkg::symbolInfoT randomInfo();
      logic [31:0]               r;
      trellisMonPkg::symbolInfoT info;
      r = $random(seed);
      info.phaseErr = r[`PHERR_BITS-1:0];
      info.index = r[16 +: `INDEX_BITS];
      return info;
   endfunction

   // --------------------
   // stimulus
   // --------------------
   task automatic driveCycle(input logic sym, input logic sym2x,
                             input trellisMonPkg::iqSampleT iq,
                             input trellisMonPkg::symbolInfoT info);
      @(posedge clk);
      #10;
      symEn = sym;
      sym2xEn = sym2x;
      iqIn = iq;
      symInfoIn = info;
   endtask

   // one symbol of 4 clocks, outputs sampled 60 ns into each clock
   // junk on the bus between strobes must not be captured
   task automatic runSymbol(input trellisMonPkg::iqSampleT iqA,
                            input trellisMonPkg::iqSampleT iqB,
                            input trellisMonPkg::symbolInfoT info);
      trellisMonPkg::iqSampleT   prevIq;
      trellisMonPkg::symbolInfoT prevInfo;
      trellisMonPkg::phSatT      prevSat;
      int                        n;
      n = infoHist.size();
      prevIq = lastIq;
      prevInfo = infoHist[n-1];
      prevSat = expectedSat(infoHist[n-3].phaseErr);
      infoHist.push_back(info);
      lastIq = iqB;
      // strobe cycle with the first half sample
      driveCycle(1'b1, 1'b1, iqA, info);
      #50;
      compareBit(quadrarySym2xEnOut, 1'b1, "2x enable in strobe cycle");
      requireSyncsLow("in strobe cycle");
      // sync cycle shows the sources from before the strobe
      driveCycle(1'b0, 1'b0, randomIq(), randomInfo());
      #50;
      compareBit(quadrarySym2xEnOut, 1'b1, "2x enable after strobe");
      compareDac(dac0, syncedWord(dac0Select, prevIq, prevInfo, prevSat), "dac0");
      compareDac(dac1, syncedWord(dac1Select, prevIq, prevInfo, prevSat), "dac1");
      compareDac(dac2, syncedWord(dac2Select, prevIq, prevInfo, prevSat), "dac2");
      // stage one is not reset, so the first strobe after reset moves an unknown value
      if (n > 3) begin
         comparePhSat(phSat, expectedSat(infoHist[n-2].phaseErr), "phSat two strobes on");
      end
      // second half sample, then idle
      driveCycle(1'b0, 1'b1, iqB, randomInfo());
      #50;
      compareBit(quadrarySym2xEnOut, 1'b0, "2x enable in half-symbol cycle");
      requireSyncsLow("in half-symbol cycle");
      driveCycle(1'b0, 1'b0, randomIq(), randomInfo());
      #50;
      compareBit(quadrarySym2xEnOut, 1'b0, "2x enable in idle cycle");
      requireSyncsLow("in idle cycle");
   endtask

   `include "trellisMonitorTests.svh"

   // --------------------
   // test sequence
   // --------------------
   initial begin
      trellisMonPkg::symbolInfoT zeroInfo;
      seed = 32'h246e;
      dacErrors = 0;
      phSatErrors = 0;
      decayErrors = 0;
      bitErrors = 0;
      clk = 1'b0;
      reset = 1'b1;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      iqIn = '0;
      symInfoIn = '0;
      busWr = '0;
      busAddr = `TRELLIS_DECAY_ADDR;
      dac0Select = `DAC_TRELLIS_I;
      dac1Select = `DAC_TRELLIS_I;
      dac2Select = `DAC_TRELLIS_I;
      // capture and pipeline registers all read zero after reset
      zeroInfo = '0;
      lastIq = '0;
      repeat (3) infoHist.push_back(zeroInfo);
      repeat (3) @(posedge clk);
      #10;
      reset = 1'b0;
      checkResetState();
      exerciseDecayReg();
      checkDacSources();
      sweepPhaseErr();
      checkSym2xEnable();
      $display("errors: dac %0d, phSat %0d, decay %0d, bit %0d",
               dacErrors, phSatErrors, decayErrors, bitErrors);
      if (dacErrors + phSatErrors + decayErrors + bitErrors == 0) begin
         $display("Verification passed");
      end
      else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
